/* rtl/cast_ctrl_pkg.sv */
// ---------------------------------------------------------------------------
// AXI4-Lite configuration port of the cast stage
// 12-bit byte addresses, 32-bit data, no burst or protection support
// the master drives axil_req_t, the slave answers with axil_rsp_t
// ---------------------------------------------------------------------------

package cast_ctrl_pkg;

  localparam int unsigned AXIL_ADDR_W = 12;
  localparam int unsigned AXIL_DATA_W = 32;
  localparam int unsigned AXIL_STRB_W = AXIL_DATA_W / 8;

  typedef logic [AXIL_ADDR_W-1:0] axil_addr_t;
  typedef logic [AXIL_DATA_W-1:0] axil_data_t;
  typedef logic [AXIL_STRB_W-1:0] axil_strb_t;
  typedef logic [1:0]             axil_resp_t;

  // register map
  localparam axil_addr_t REG_CTRL  = 12'h000;
  localparam axil_addr_t REG_COUNT = 12'h004;

  localparam axil_resp_t RESP_OKAY   = 2'b00;
  localparam axil_resp_t RESP_SLVERR = 2'b10;

  typedef struct packed {
    logic       awvalid;
    axil_addr_t awaddr;
    logic       wvalid;
    axil_data_t wdata;
    axil_strb_t wstrb;
    logic       bready;
    logic       arvalid;
    axil_addr_t araddr;
    logic       rready;
  } axil_req_t;

  typedef struct packed {
    logic       awready;
    logic       wready;
    logic       bvalid;
    axil_resp_t bresp;
    logic       arready;
    logic       rvalid;
    axil_data_t rdata;
    axil_resp_t rresp;
  } axil_rsp_t;

  typedef enum logic [1:0] {
    AXIL_IDLE,
    AXIL_WRESP,
    AXIL_RRESP
  } axil_state_e;

endpackage : cast_ctrl_pkg

/* rtl/cast_ctrl_regs.sv */
// ---------------------------------------------------------------------------
// AXI4-Lite slave with the cast control register and the word counter
// one transaction at a time and a write wins over a read in the same cycle
// unmapped addresses answer SLVERR and read as zero
// only strobe byte 0 is looked at for the control register
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module cast_ctrl_regs (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  cast_ctrl_pkg::axil_req_t axil_req_i,
  output cast_ctrl_pkg::axil_rsp_t axil_rsp_o,
  input  logic                     accept_i,
  output fp_cast_pkg::cast_cfg_t   cfg_o
);

  import fp_cast_pkg::*;
  import cast_ctrl_pkg::*;

  axil_state_e state_q;
  axil_state_e state_d;
  cast_cfg_t   ctrl_q;
  axil_data_t  count_q;
  logic        wr_take;
  logic        rd_take;
  axil_resp_t  wr_resp;
  axil_resp_t  rd_resp;
  axil_data_t  rd_data;
  axil_resp_t  bresp_q;
  axil_resp_t  rresp_q;
  axil_data_t  rdata_q;

  assign wr_take = (state_q == AXIL_IDLE) && axil_req_i.awvalid && axil_req_i.wvalid;
  assign rd_take = (state_q == AXIL_IDLE) && axil_req_i.arvalid && !wr_take;

  // address decode
  always_comb begin
    wr_resp = RESP_SLVERR;
    rd_resp = RESP_SLVERR;
    rd_data = '0;
    if (axil_req_i.awaddr == REG_CTRL || axil_req_i.awaddr == REG_COUNT) begin
      wr_resp = RESP_OKAY;
    end
    case (axil_req_i.araddr)
      REG_CTRL: begin
        rd_resp = RESP_OKAY;
        rd_data = axil_data_t'(ctrl_q);
      end
      REG_COUNT: begin
        rd_resp = RESP_OKAY;
        rd_data = count_q;
      end
      default: begin
        rd_resp = RESP_SLVERR;
      end
    endcase
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      AXIL_IDLE: begin
        if (wr_take) begin
          state_d = AXIL_WRESP;
        end else if (rd_take) begin
          state_d = AXIL_RRESP;
        end
      end
      AXIL_WRESP: begin
        if (axil_req_i.bready) begin
          state_d = AXIL_IDLE;
        end
      end
      AXIL_RRESP: begin
        if (axil_req_i.rready) begin
          state_d = AXIL_IDLE;
        end
      end
      default: begin
        state_d = AXIL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= AXIL_IDLE;
      ctrl_q  <= '0;
      count_q <= '0;
    end else begin
      state_q <= state_d;
      if (wr_take && axil_req_i.awaddr == REG_CTRL && axil_req_i.wstrb[0]) begin
        ctrl_q <= cast_cfg_t'(axil_req_i.wdata[$bits(cast_cfg_t)-1:0]);
      end
      // wraps at 32 bits
      if (accept_i) begin
        count_q <= count_q + 32'd1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_take) begin
      bresp_q <= wr_resp;
    end
    if (rd_take) begin
      rresp_q <= rd_resp;
      rdata_q <= rd_data;
    end
  end

  always_comb begin
    axil_rsp_o         = '0;
    axil_rsp_o.awready = wr_take;
    axil_rsp_o.wready  = wr_take;
    axil_rsp_o.bvalid  = (state_q == AXIL_WRESP);
    axil_rsp_o.bresp   = bresp_q;
    axil_rsp_o.arready = rd_take;
    axil_rsp_o.rvalid  = (state_q == AXIL_RRESP);
    axil_rsp_o.rdata   = rdata_q;
    axil_rsp_o.rresp   = rresp_q;
  end

  assign cfg_o = ctrl_q;

endmodule : cast_ctrl_regs

/* rtl/cast_in.sv */
// ---------------------------------------------------------------------------
// casts the low half of a memory word lane by lane, or passes it through
// lane i reads bits 8i+7:8i and writes bits 16i+15:16i of the result
// the upper 32 source bits are dropped when casting
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module cast_in (
  input  logic                   cast_i,
  input  fp_cast_pkg::fp8_fmt_e  src_fmt_i,
  input  fp_cast_pkg::data_word_t src_i,
  output fp_cast_pkg::data_word_t dst_o
);

  import fp_cast_pkg::*;

  data_word_t cast_word;

  generate
    for (genvar i = 0; i < NUM_CAST; i++) begin : gen_lanes
      fp8_to_fp16_lane u_lane (
        .nar_i  (src_i[i*NARROW_W +: NARROW_W]),
        .fmt_i  (src_fmt_i),
        .wide_o (cast_word[i*WIDE_W +: WIDE_W])
      );
    end
  endgenerate

  assign dst_o = cast_i ? cast_word : src_i;

endmodule : cast_in

/* rtl/cast_stream.sv */
// ---------------------------------------------------------------------------
// one-entry output register around the cast unit, valid/ready on both sides
// the configuration is taken at acceptance, one word per cycle throughput
// accept_o pulses for every input handshake
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module cast_stream (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  fp_cast_pkg::cast_cfg_t  cfg_i,
  input  logic                    in_valid_i,
  input  fp_cast_pkg::data_word_t in_data_i,
  output logic                    in_ready_o,
  output logic                    out_valid_o,
  output fp_cast_pkg::data_word_t out_data_o,
  input  logic                    out_ready_i,
  output logic                    accept_o
);

  import fp_cast_pkg::*;

  data_word_t cast_data;
  data_word_t out_data_q;
  logic       out_valid_q;
  logic       accept;

  cast_in u_cast_in (
    .cast_i    (cfg_i.enable),
    .src_fmt_i (cfg_i.fmt),
    .src_i     (in_data_i),
    .dst_o     (cast_data)
  );

  // room when empty, or when the held word leaves this cycle
  assign in_ready_o = !out_valid_q || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (accept) begin
      out_valid_q <= 1'b1;
    end else if (out_ready_i) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      out_data_q <= cast_data;
    end
  end

  assign out_valid_o = out_valid_q;
  assign out_data_o  = out_data_q;
  assign accept_o    = accept;

endmodule : cast_stream

/* rtl/cast_top.sv */
// ---------------------------------------------------------------------------
// input-cast stage, AXI4-Lite configuration plus a valid/ready data stream
// output data follows an accepted word by one cycle
// reset leaves the stage in bypass with E4M3 selected
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module cast_top (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  cast_ctrl_pkg::axil_req_t axil_req_i,
  output cast_ctrl_pkg::axil_rsp_t axil_rsp_o,
  input  logic                     in_valid_i,
  input  fp_cast_pkg::data_word_t  in_data_i,
  output logic                     in_ready_o,
  output logic                     out_valid_o,
  output fp_cast_pkg::data_word_t  out_data_o,
  input  logic                     out_ready_i
);

  import fp_cast_pkg::*;

  cast_cfg_t cfg;
  logic      accept;

  cast_ctrl_regs u_regs (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .axil_req_i (axil_req_i),
    .axil_rsp_o (axil_rsp_o),
    .accept_i   (accept),
    .cfg_o      (cfg)
  );

  cast_stream u_stream (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_i       (cfg),
    .in_valid_i  (in_valid_i),
    .in_data_i   (in_data_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .out_ready_i (out_ready_i),
    .accept_o    (accept)
  );

endmodule : cast_top

/* rtl/fp8_to_fp16_lane.sv */
// ---------------------------------------------------------------------------
// widens one FP8 value to FP16, purely combinational
// the widening is exact, so there is no rounding and there are no flags
// E4M3 NaN becomes the quiet FP16 NaN with the same sign
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module fp8_to_fp16_lane (
  input  fp_cast_pkg::fp8_t     nar_i,
  input  fp_cast_pkg::fp8_fmt_e fmt_i,
  output fp_cast_pkg::fp16_t    wide_o
);

  import fp_cast_pkg::*;

  logic                  sign;
  logic [E4M3_EXP_W-1:0] exp8;
  logic [E4M3_MAN_W-1:0] man8;
  logic [FP16_EXP_W-1:0] exp16;
  logic [FP16_MAN_W-1:0] man16;
  fp16_t                 e4m3_wide;
  fp16_t                 e5m2_wide;

  assign sign = nar_i[NARROW_W-1];
  assign exp8 = nar_i[E4M3_MAN_W +: E4M3_EXP_W];
  assign man8 = nar_i[E4M3_MAN_W-1:0];

  always_comb begin
    exp16 = '0;
    man16 = '0;
    if (exp8 == '0) begin
      // subnormals are normalised around the leading mantissa one
      casez (man8)
        3'b1??: begin
          exp16 = FP16_EXP_W'(E4M3_SUB_EXP + 2);
          man16 = {man8[1:0], {(FP16_MAN_W-2){1'b0}}};
        end
        3'b01?: begin
          exp16 = FP16_EXP_W'(E4M3_SUB_EXP + 1);
          man16 = {man8[0], {(FP16_MAN_W-1){1'b0}}};
        end
        3'b001: begin
          exp16 = FP16_EXP_W'(E4M3_SUB_EXP);
        end
        default: begin
          // signed zero keeps exponent and mantissa clear
          exp16 = '0;
        end
      endcase
    end else if (exp8 == '1 && man8 == '1) begin
      exp16 = '1;
      man16 = {1'b1, {(FP16_MAN_W-1){1'b0}}};
    end else begin
      exp16 = FP16_EXP_W'(exp8) + FP16_EXP_W'(E4M3_BIAS_ADJ);
      man16 = {man8, {(FP16_MAN_W-E4M3_MAN_W){1'b0}}};
    end
  end

  assign e4m3_wide = {sign, exp16, man16};

  // E5M2 shares the FP16 exponent field, so padding is enough
  assign e5m2_wide = {nar_i, {(WIDE_W-NARROW_W){1'b0}}};

  assign wide_o = (fmt_i == FMT_E5M2) ? e5m2_wide : e4m3_wide;

endmodule : fp8_to_fp16_lane

/* rtl/fp_cast_pkg.sv */
// ---------------------------------------------------------------------------
// data word, lane and format definitions for the FP8 to FP16 input cast
// one memory word is 64 bits; when casting only the low 32 bits are used
// E4M3 has no infinities and one NaN pattern per sign
// ---------------------------------------------------------------------------

package fp_cast_pkg;

  // word and lane widths
  localparam int unsigned DATA_W   = 64;
  localparam int unsigned NARROW_W = 8;
  localparam int unsigned WIDE_W   = 16;
  localparam int unsigned NUM_CAST = DATA_W / WIDE_W;

  // field widths of the two ends of the cast
  localparam int unsigned E4M3_EXP_W = 4;
  localparam int unsigned E4M3_MAN_W = 3;
  localparam int unsigned FP16_EXP_W = 5;
  localparam int unsigned FP16_MAN_W = 10;

  localparam int unsigned E4M3_BIAS = 7;
  localparam int unsigned FP16_BIAS = 15;

  // added to an E4M3 normal exponent to get the FP16 exponent
  localparam int unsigned E4M3_BIAS_ADJ = FP16_BIAS - E4M3_BIAS;

  // FP16 exponent of an E4M3 subnormal whose leading one sits at mantissa bit 0
  localparam int unsigned E4M3_SUB_EXP = E4M3_BIAS_ADJ - E4M3_MAN_W + 1;

  typedef logic [DATA_W-1:0]   data_word_t;
  typedef logic [NARROW_W-1:0] fp8_t;
  typedef logic [WIDE_W-1:0]   fp16_t;

  typedef enum logic {
    FMT_E4M3 = 1'b0,
    FMT_E5M2 = 1'b1
  } fp8_fmt_e;

  // field order matches the control register with the format above the enable
  typedef struct packed {
    fp8_fmt_e fmt;
    logic     enable;
  } cast_cfg_t;

endpackage : fp_cast_pkg

/* run_sim.sh */
#!/bin/sh
# build the cast stage testbench with Verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -j 0 --Mdir "$BUILD_DIR" \
  --top-module tb_cast_top -f sources.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$BUILD_DIR/Vtb_cast_top" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "test failed" "$LOG"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

echo "simulation finished cleanly"
exit 0

/* sources.f */
rtl/fp_cast_pkg.sv
rtl/cast_ctrl_pkg.sv
rtl/fp8_to_fp16_lane.sv
rtl/cast_in.sv
rtl/cast_stream.sv
rtl/cast_ctrl_regs.sv
rtl/cast_top.sv
verification/cast_top_assertions.sv
verification/tb_cast_top.sv

/* verification/cast_top_assertions.sv */
// ---------------------------------------------------------------------------
// valid/ready protocol checks bound into the stream stage and register block
// one generic checker, instanced once per channel that holds a response
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module cast_top_assertions #(
  parameter int unsigned DATA_W = 1
) (
  input logic              clk_i,
  input logic              rst_n_i,
  input logic              valid_i,
  input logic              ready_i,
  input logic [DATA_W-1:0] data_i
);

  // a stalled transfer keeps both its valid and its payload
  hold_valid: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i && !ready_i |=> valid_i)
    else $error("valid dropped before ready");

  hold_data: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    valid_i && !ready_i |=> $stable(data_i))
    else $error("payload changed while stalled");

  idle_after_reset: assert property (@(posedge clk_i) $rose(rst_n_i) |-> !valid_i)
    else $error("valid high in the first cycle after reset");

endmodule : cast_top_assertions

bind cast_stream cast_top_assertions #(.DATA_W(fp_cast_pkg::DATA_W)) u_out_checks (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .valid_i (out_valid_o),
  .ready_i (out_ready_i),
  .data_i  (out_data_o)
);

bind cast_ctrl_regs cast_top_assertions #(.DATA_W(2)) u_b_checks (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .valid_i (axil_rsp_o.bvalid),
  .ready_i (axil_req_i.bready),
  .data_i  (axil_rsp_o.bresp)
);

bind cast_ctrl_regs cast_top_assertions #(.DATA_W(34)) u_r_checks (
  .clk_i   (clk_i),
  .rst_n_i (rst_n_i),
  .valid_i (axil_rsp_o.rvalid),
  .ready_i (axil_req_i.rready),
  .data_i  ({axil_rsp_o.rresp, axil_rsp_o.rdata})
);

/* verification/tb_cast_top.sv */
// ---------------------------------------------------------------------------
// directed testbench for the input-cast stage
// inputs change on the falling edge, outputs are read 1 ns after it
// the first mismatch ends the run and a watchdog bounds its length
// ---------------------------------------------------------------------------

`timescale 1ns/10ps

module tb_cast_top;

  import fp_cast_pkg::*;
  import cast_ctrl_pkg::*;

  localparam logic [31:0] LFSR_SEED  = 32'h671f_cce0;
  localparam int unsigned MAX_CYCLES = 4000;

  logic        clk;
  logic        rst_n;
  axil_req_t   req;
  axil_rsp_t   rsp;
  logic        in_valid;
  data_word_t  in_data;
  logic        in_ready;
  logic        out_valid;
  data_word_t  out_data;
  logic        out_ready;
  logic [31:0] lfsr;
  int unsigned cycles;
  int unsigned words_sent;
  logic        ready_random;
  cast_cfg_t   model_cfg;
  string       test_name;
  data_word_t  exp_q[$];
  int unsigned acc_q[$];

  cast_top u_cast_top (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .axil_req_i  (req),
    .axil_rsp_o  (rsp),
    .in_valid_i  (in_valid),
    .in_data_i   (in_data),
    .in_ready_o  (in_ready),
    .out_valid_o (out_valid),
    .out_data_o  (out_data),
    .out_ready_i (out_ready)
  );

  always #10 clk = ~clk;

  initial begin : watchdog
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
    $display("test failed");
    $fatal(1, "timeout");
  end

  // Galois LFSR for x^32 + x^22 + x^2 + x + 1
  function automatic logic random_bit();
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    return lfsr[0];
  endfunction

  function automatic data_word_t random_word();
    data_word_t w;
    for (int i = 0; i < DATA_W; i++) begin
      w = {w[DATA_W-2:0], random_bit()};
    end
    return w;
  endfunction

  function automatic fp16_t ref_lane(input fp8_t v, input logic e5m2);
    logic [3:0] e;
    logic [2:0] m;
    logic [4:0] x;
    e = v[6:3];
    m = v[2:0];
    if (e5m2) return {v, 8'h00};
    if (e == 4'hf && m == 3'h7) return {v[7], 5'h1f, 10'h200};
    if (e == 4'h0 && m == 3'h0) return {v[7], 15'h0000};
    if (e != 4'h0) return {v[7], 5'(e) + 5'd8, m, 7'h00};
    // a subnormal is m * 2^-9 so a leading one at bit 2 gives 2^-7
    x = 5'd8;
    while (!m[2]) begin
      m = m << 1;
      x = x - 5'd1;
    end
    return {v[7], x, m[1:0], 8'h00};
  endfunction

  function automatic data_word_t ref_word(input data_word_t w, input cast_cfg_t cfg);
    data_word_t r;
    if (!cfg.enable) return w;
    for (int i = 0; i < NUM_CAST; i++) begin
      r[16*i +: 16] = ref_lane(w[8*i +: 8], cfg.fmt == FMT_E5M2);
    end
    return r;
  endfunction

  task automatic check_value(input string what, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (expected === actual) else begin
      $display("FAILED %s: %s expected %h actual %h", test_name, what, expected, actual);
      $display("test failed");
      $fatal(1, "mismatch");
    end
  endtask

  task automatic axil_write(input axil_addr_t addr, input axil_data_t data,
                            input axil_resp_t exp_resp);
    @(negedge clk);
    req.awvalid = 1'b1;
    req.awaddr  = addr;
    req.wvalid  = 1'b1;
    req.wdata   = data;
    req.wstrb   = 4'hf;
    #1;
    while (!rsp.awready) begin
      @(negedge clk);
      #1;
    end
    check_value("wready", 64'd1, 64'(rsp.wready));
    @(negedge clk);
    // the register took the value on the handshake edge
    if (addr == REG_CTRL) model_cfg = cast_cfg_t'(data[1:0]);
    req.awvalid = 1'b0;
    req.wvalid  = 1'b0;
    #1;
    while (!rsp.bvalid) begin
      @(negedge clk);
      #1;
    end
    check_value("bresp", 64'(exp_resp), 64'(rsp.bresp));
    // the response waits one cycle before it is taken
    @(negedge clk);
    req.bready = 1'b1;
    @(negedge clk);
    req.bready = 1'b0;
  endtask

  task automatic axil_read(input axil_addr_t addr, input axil_data_t exp_data,
                           input axil_resp_t exp_resp);
    @(negedge clk);
    req.arvalid = 1'b1;
    req.araddr  = addr;
    #1;
    while (!rsp.arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    req.arvalid = 1'b0;
    #1;
    while (!rsp.rvalid) begin
      @(negedge clk);
      #1;
    end
    check_value("rresp", 64'(exp_resp), 64'(rsp.rresp));
    check_value("rdata", 64'(exp_data), 64'(rsp.rdata));
    // the response waits one cycle before it is taken
    @(negedge clk);
    req.rready = 1'b1;
    @(negedge clk);
    req.rready = 1'b0;
  endtask

  task automatic send_word(input data_word_t word);
    @(negedge clk);
    in_valid = 1'b1;
    in_data  = word;
    #1;
    while (!in_ready) begin
      @(negedge clk);
      #1;
    end
    exp_q.push_back(ref_word(word, model_cfg));
    acc_q.push_back(cycles);
    words_sent++;
  endtask

  task automatic expect_word();
    data_word_t  expected;
    int unsigned acc;
    @(negedge clk);
    out_ready = ready_random ? random_bit() : 1'b1;
    #1;
    while (!(out_valid && out_ready)) begin
      @(negedge clk);
      out_ready = ready_random ? random_bit() : 1'b1;
      #1;
    end
    expected = exp_q.pop_front();
    acc = acc_q.pop_front();
    if (!ready_random) check_value("latency", 64'd1, 64'(cycles - acc));
    check_value("out_data", expected, out_data);
  endtask

  task automatic run_stream(input data_word_t words[$]);
    fork
      begin
        foreach (words[i]) send_word(words[i]);
        @(negedge clk);
        in_valid = 1'b0;
      end
      repeat (words.size()) expect_word();
    join
  endtask

  task automatic test_registers();
    test_name = "registers";
    axil_read(REG_CTRL, 32'h0, RESP_OKAY);
    axil_read(REG_COUNT, 32'h0, RESP_OKAY);
    axil_write(REG_CTRL, 32'hffff_ffff, RESP_OKAY);
    axil_read(REG_CTRL, 32'h3, RESP_OKAY);
    axil_write(REG_CTRL, 32'h0, RESP_OKAY);
    axil_write(12'h010, 32'h1234_5678, RESP_SLVERR);
    axil_read(12'h010, 32'h0, RESP_SLVERR);
  endtask

  task automatic test_bypass();
    data_word_t words[$];
    test_name = "bypass";
    repeat (32) words.push_back(random_word());
    run_stream(words);
  endtask

  // fixed corner words first and then 64 random ones
  task automatic test_widening(input string name, input axil_data_t ctrl,
                               input data_word_t w0, input data_word_t w1,
                               input data_word_t w2, input data_word_t w3);
    data_word_t words[$];
    test_name = name;
    words = '{w0, w1, w2, w3};
    repeat (64) words.push_back(random_word());
    axil_write(REG_CTRL, ctrl, RESP_OKAY);
    run_stream(words);
  endtask

  task automatic test_backpressure();
    data_word_t  words[$];
    int unsigned start;
    test_name = "backpressure";
    repeat (48) words.push_back(random_word());
    axil_write(REG_CTRL, 32'h1, RESP_OKAY);
    start = words_sent;
    ready_random = 1'b1;
    fork
      run_stream(words);
      begin
        wait (words_sent >= start + 24);
        axil_write(REG_CTRL, 32'h3, RESP_OKAY);
      end
    join
    ready_random = 1'b0;
  endtask

  task automatic test_counter();
    test_name = "counter";
    axil_read(REG_COUNT, axil_data_t'(words_sent), RESP_OKAY);
    axil_write(REG_COUNT, 32'h0, RESP_OKAY);
    axil_read(REG_COUNT, axil_data_t'(words_sent), RESP_OKAY);
  endtask

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    req          = '0;
    in_valid     = 1'b0;
    in_data      = '0;
    out_ready    = 1'b1;
    lfsr         = LFSR_SEED;
    words_sent   = 0;
    ready_random = 1'b0;
    model_cfg    = '0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    test_registers();
    test_bypass();
    // zeros, subnormals, max normals and NaN with junk in the upper half
    test_widening("e4m3", 32'h1, 64'hdead_beef_0201_8000, 64'h1234_5678_8704_0603,
                  64'hffff_ffff_ff7f_fe7e, 64'h0000_0000_7808_8881);
    // infinities, NaNs, subnormals and max normal
    test_widening("e5m2", 32'h3, 64'hdead_beef_7f7e_fc7c, 64'h0bad_f00d_0301_8000,
                  64'h0000_0000_fb7b_fd7d, 64'hffff_ffff_8483_0404);
    test_backpressure();
    test_counter();
    $display("test passed");
    $finish;
  end

endmodule : tb_cast_top
